/* include/decode_defines.svh */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Datapath widths of the decode stage
`define INSN_W      32
`define PC_W        32
`define REG_IDX_W   5

// ALU0 immediate holds the 20-bit LU12I field or a 12-bit field
`define ALU_IMM_W   20

// Branch immediate holds the 26-bit B/BL offset
`define BRU_IMM_W   26

// BL writes its return address here
`define LINK_REG    1

`endif

/* design/decode_pkg.sv */
`include "decode_defines.svh"

package decode_pkg;

    typedef enum logic [1:0] {
        IQ_NONE = 2'd0,
        IQ_ALU0 = 2'd1,
        IQ_ALU1 = 2'd2,
        IQ_BRU  = 2'd3
    } iq_e;

    typedef enum logic [4:0] {
        ALU0_LU12I = 5'd0,
        ALU0_SLTI  = 5'd1,
        ALU0_SLTUI = 5'd2,
        ALU0_ADDI  = 5'd3,
        ALU0_ANDI  = 5'd4,
        ALU0_ORI   = 5'd5,
        ALU0_XORI  = 5'd6,
        ALU0_ADD   = 5'd7,
        ALU0_SUB   = 5'd8,
        ALU0_SLT   = 5'd9,
        ALU0_SLTU  = 5'd10,
        ALU0_NOR   = 5'd11,
        ALU0_AND   = 5'd12,
        ALU0_OR    = 5'd13,
        ALU0_XOR   = 5'd14,
        ALU0_SLL   = 5'd15,
        ALU0_SRL   = 5'd16,
        ALU0_SRA   = 5'd17,
        ALU0_SLLI  = 5'd21,     // 18..20 held the counter reads
        ALU0_SRLI  = 5'd22,
        ALU0_SRAI  = 5'd23
    } alu0_op_e;

    typedef enum logic [2:0] {
        ALU1_DIV   = 3'd0,
        ALU1_MOD   = 3'd1,
        ALU1_DIVU  = 3'd2,
        ALU1_MODU  = 3'd3,
        ALU1_MUL   = 3'd4,
        ALU1_MULH  = 3'd5,
        ALU1_MULHU = 3'd6
    } alu1_op_e;

    typedef enum logic [3:0] {
        BRU_PCADDU12I = 4'd0,
        BRU_JIRL      = 4'd1,
        BRU_B         = 4'd2,
        BRU_BL        = 4'd3,
        BRU_BEQ       = 4'd4,
        BRU_BNE       = 4'd5,
        BRU_BLT       = 4'd6,
        BRU_BGE       = 4'd7,
        BRU_BLTU      = 4'd8,
        BRU_BGEU      = 4'd9
    } bru_op_e;

    typedef struct packed {
        logic                   valid;
        logic [`PC_W-1:0]       pc;
        logic [`INSN_W-1:0]     insn;
    } fetch_pkt_t;

    typedef struct packed {
        alu0_op_e               alu0_op;
        alu1_op_e               alu1_op;
        bru_op_e                bru_op;
        logic [`ALU_IMM_W-1:0]  alu_imm;
        logic [`BRU_IMM_W-1:0]  bru_imm;
    } op_fields_t;

    typedef struct packed {
        logic                   dst_en;
        logic [`REG_IDX_W-1:0]  dst;
        logic                   src1_en;
        logic [`REG_IDX_W-1:0]  src1;
        logic                   src2_en;
        logic [`REG_IDX_W-1:0]  src2;
    } reg_fields_t;

    typedef struct packed {
        logic                   valid;
        iq_e                    queue;
        op_fields_t             ops;
        reg_fields_t            regs;
    } uop_t;

endpackage

/* design/iq_classifier.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module iq_classifier (
    input  logic [`INSN_W-1:0] insn,
    input  logic               valid,
    output decode_pkg::iq_e    queue
);

    logic is_lu12i;
    logic is_pcaddu;
    logic is_branch;
    logic is_imm_op;
    logic is_shift_imm;
    logic is_reg_op;
    logic is_mul;
    logic is_div;
    logic rr_func_ok;

    always_comb begin
        case (insn[19:15])
            5'b00000, 5'b00010, 5'b00100, 5'b00101,
            5'b01000, 5'b01001, 5'b01010, 5'b01011,
            5'b01110, 5'b01111, 5'b10000: rr_func_ok = 1'b1;
            default: rr_func_ok = 1'b0;
        endcase
    end

    assign is_lu12i     = (insn[31:25] == 7'b0001010);
    assign is_pcaddu    = (insn[31:25] == 7'b0001110);
    assign is_branch    = (insn[31:26] >= 6'b010011) && (insn[31:26] <= 6'b011011);
    assign is_imm_op    = (insn[31:25] == 7'b0000001) &&
                          (insn[24:22] != 3'b011) && (insn[24:22] != 3'b100);
    assign is_shift_imm = (insn[31:20] == 12'b000000000100) &&
                          (insn[17:15] == 3'b001) && (insn[19:18] != 2'b11);
    assign is_reg_op    = (insn[31:20] == 12'b000000000001) && rr_func_ok;
    assign is_mul       = (insn[31:17] == 15'b000000000001110) && (insn[16:15] != 2'b11);
    assign is_div       = (insn[31:17] == 15'b000000000010000);

    always_comb begin
        queue = decode_pkg::IQ_NONE;
        if (valid) begin
            if (is_lu12i || is_imm_op || is_shift_imm || is_reg_op) begin
                queue = decode_pkg::IQ_ALU0;
            end else if (is_mul || is_div) begin
                queue = decode_pkg::IQ_ALU1;
            end else if (is_pcaddu || is_branch) begin
                queue = decode_pkg::IQ_BRU;
            end
        end
    end

endmodule

/* design/op_decoder.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module op_decoder (
    input  logic [`INSN_W-1:0]      insn,
    input  decode_pkg::iq_e         queue,
    output decode_pkg::op_fields_t  ops
);

    logic is_lu12i;
    logic is_b_bl;

    // Only LU12I has bit 28 set among the ALU0 encodings
    assign is_lu12i = insn[28];
    assign is_b_bl  = (insn[29:27] == 3'b010);

    always_comb begin
        ops = '0;
        case (queue)
            decode_pkg::IQ_ALU0: begin
                ops.alu_imm = is_lu12i ? insn[24:5] : {8'd0, insn[21:10]};
                if (is_lu12i) begin
                    ops.alu0_op = decode_pkg::ALU0_LU12I;
                end else if (insn[25]) begin     // 12-bit immediate forms
                    case (insn[24:22])
                        3'b000:  ops.alu0_op = decode_pkg::ALU0_SLTI;
                        3'b001:  ops.alu0_op = decode_pkg::ALU0_SLTUI;
                        3'b010:  ops.alu0_op = decode_pkg::ALU0_ADDI;
                        3'b101:  ops.alu0_op = decode_pkg::ALU0_ANDI;
                        3'b110:  ops.alu0_op = decode_pkg::ALU0_ORI;
                        3'b111:  ops.alu0_op = decode_pkg::ALU0_XORI;
                        default: ops.alu0_op = decode_pkg::ALU0_LU12I;
                    endcase
                end else if (insn[22]) begin     // Shift by ui5
                    case (insn[19:18])
                        2'b00:   ops.alu0_op = decode_pkg::ALU0_SLLI;
                        2'b01:   ops.alu0_op = decode_pkg::ALU0_SRLI;
                        2'b10:   ops.alu0_op = decode_pkg::ALU0_SRAI;
                        default: ops.alu0_op = decode_pkg::ALU0_LU12I;
                    endcase
                end else begin
                    case (insn[19:15])
                        5'b00000: ops.alu0_op = decode_pkg::ALU0_ADD;
                        5'b00010: ops.alu0_op = decode_pkg::ALU0_SUB;
                        5'b00100: ops.alu0_op = decode_pkg::ALU0_SLT;
                        5'b00101: ops.alu0_op = decode_pkg::ALU0_SLTU;
                        5'b01000: ops.alu0_op = decode_pkg::ALU0_NOR;
                        5'b01001: ops.alu0_op = decode_pkg::ALU0_AND;
                        5'b01010: ops.alu0_op = decode_pkg::ALU0_OR;
                        5'b01011: ops.alu0_op = decode_pkg::ALU0_XOR;
                        5'b01110: ops.alu0_op = decode_pkg::ALU0_SLL;
                        5'b01111: ops.alu0_op = decode_pkg::ALU0_SRL;
                        5'b10000: ops.alu0_op = decode_pkg::ALU0_SRA;
                        default:  ops.alu0_op = decode_pkg::ALU0_LU12I;
                    endcase
                end
            end
            decode_pkg::IQ_ALU1: begin
                case ({insn[21], insn[16:15]})  // Bit 21 splits divide from multiply
                    3'b100:  ops.alu1_op = decode_pkg::ALU1_DIV;
                    3'b101:  ops.alu1_op = decode_pkg::ALU1_MOD;
                    3'b110:  ops.alu1_op = decode_pkg::ALU1_DIVU;
                    3'b111:  ops.alu1_op = decode_pkg::ALU1_MODU;
                    3'b000:  ops.alu1_op = decode_pkg::ALU1_MUL;
                    3'b001:  ops.alu1_op = decode_pkg::ALU1_MULH;
                    3'b010:  ops.alu1_op = decode_pkg::ALU1_MULHU;
                    default: ops.alu1_op = decode_pkg::ALU1_DIV;
                endcase
            end
            decode_pkg::IQ_BRU: begin
                if (!insn[30]) begin
                    ops.bru_op  = decode_pkg::BRU_PCADDU12I;
                    ops.bru_imm = {6'd0, insn[24:5]};
                end else begin
                    case (insn[29:26])
                        4'b0011: ops.bru_op = decode_pkg::BRU_JIRL;
                        4'b0100: ops.bru_op = decode_pkg::BRU_B;
                        4'b0101: ops.bru_op = decode_pkg::BRU_BL;
                        4'b0110: ops.bru_op = decode_pkg::BRU_BEQ;
                        4'b0111: ops.bru_op = decode_pkg::BRU_BNE;
                        4'b1000: ops.bru_op = decode_pkg::BRU_BLT;
                        4'b1001: ops.bru_op = decode_pkg::BRU_BGE;
                        4'b1010: ops.bru_op = decode_pkg::BRU_BLTU;
                        4'b1011: ops.bru_op = decode_pkg::BRU_BGEU;
                        default: ops.bru_op = decode_pkg::BRU_PCADDU12I;
                    endcase
                    // offs26 is split, high half sits in bits 9:0
                    ops.bru_imm = is_b_bl ? {insn[9:0], insn[25:10]} : {10'd0, insn[25:10]};
                end
            end
            default: ;
        endcase
    end

endmodule

/* design/operand_decoder.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module operand_decoder (
    input  logic [`INSN_W-1:0]      insn,
    input  decode_pkg::iq_e         queue,
    output decode_pkg::reg_fields_t regs
);

    logic is_jirl;
    logic is_bl;
    logic is_pcaddu;
    logic is_cond_br;
    logic is_lu12i;
    logic is_rr_op;

    assign is_jirl    = (insn[31:26] == 6'b010011);
    assign is_bl      = (insn[31:26] == 6'b010101);
    assign is_pcaddu  = !insn[30];       // Only BRU encoding with bit 30 low
    assign is_cond_br = insn[30] && (insn[29:26] >= 4'b0110);
    assign is_lu12i   = insn[28];
    assign is_rr_op   = (insn[31:20] == 12'b000000000001);

    always_comb begin
        regs = '0;
        if (queue != decode_pkg::IQ_NONE) begin
            regs.src1 = insn[9:5];
            regs.dst  = (queue == decode_pkg::IQ_BRU && is_bl) ?
                        `REG_IDX_W'(`LINK_REG) : insn[4:0];
            // Conditional branches compare rj against rd
            regs.src2 = (queue == decode_pkg::IQ_BRU && is_cond_br) ?
                        insn[4:0] : insn[14:10];
        end
        case (queue)
            decode_pkg::IQ_ALU0: begin
                regs.dst_en  = 1'b1;
                regs.src1_en = !is_lu12i;
                regs.src2_en = is_rr_op;
            end
            decode_pkg::IQ_ALU1: begin
                regs.dst_en  = 1'b1;
                regs.src1_en = 1'b1;
                regs.src2_en = 1'b1;
            end
            decode_pkg::IQ_BRU: begin
                regs.dst_en  = is_jirl || is_bl || is_pcaddu;
                regs.src1_en = is_jirl || is_cond_br;
                regs.src2_en = is_cond_br;
            end
            default: ;
        endcase
    end

endmodule

/* design/decode_stage_reg.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_stage_reg (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    hold,
    input  logic                    valid,
    input  logic [`PC_W-1:0]        pc,
    input  decode_pkg::iq_e         queue,
    input  decode_pkg::op_fields_t  ops,
    input  decode_pkg::reg_fields_t regs,
    output decode_pkg::uop_t        uop,
    output logic [`PC_W-1:0]        pc_out,
    output logic                    illegal
);

    logic take;

    assign take = !flush && !hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop     <= '0;
            illegal <= 1'b0;
        end else if (flush) begin       // Flush wins over hold
            uop     <= '0;
            illegal <= 1'b0;
        end else if (!hold) begin
            uop.valid <= valid && (queue != decode_pkg::IQ_NONE);
            uop.queue <= valid ? queue : decode_pkg::IQ_NONE;
            uop.ops   <= valid ? ops : '0;
            uop.regs  <= valid ? regs : '0;
            illegal   <= valid && (queue == decode_pkg::IQ_NONE);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_out <= '0;
        end else if (take && valid) begin  // Unchanged by flush or bubbles
            pc_out <= pc;
        end
    end

endmodule

/* design/decode_top.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  decode_pkg::fetch_pkt_t  fetch,
    input  logic                    hold,
    input  logic                    flush,
    output decode_pkg::uop_t        uop,
    output logic [`PC_W-1:0]        pc_out,
    output logic                    illegal
);

    decode_pkg::iq_e         queue;
    decode_pkg::op_fields_t  ops;
    decode_pkg::reg_fields_t regs;

    iq_classifier u_iq_classifier (
        .insn   (fetch.insn),
        .valid  (fetch.valid),
        .queue  (queue)
    );

    op_decoder u_op_decoder (
        .insn   (fetch.insn),
        .queue  (queue),
        .ops    (ops)
    );

    operand_decoder u_operand_decoder (
        .insn   (fetch.insn),
        .queue  (queue),
        .regs   (regs)
    );

    decode_stage_reg u_decode_stage_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .hold    (hold),
        .valid   (fetch.valid),
        .pc      (fetch.pc),
        .queue   (queue),
        .ops     (ops),
        .regs    (regs),
        .uop     (uop),
        .pc_out  (pc_out),
        .illegal (illegal)
    );

endmodule

/* sim/decode_ref.svh */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected decode of one fetched word, straight from the LoongArch encodings
function automatic decode_pkg::uop_t ref_decode(input logic valid,
                                                input logic [`INSN_W-1:0] insn,
                                                output logic ill);
    decode_pkg::uop_t u;
    logic [1:0] q;
    logic [4:0] a0;
    logic [2:0] a1;
    logic [3:0] br;
    logic cond_br;
    u  = '0;
    q  = decode_pkg::IQ_NONE;
    a0 = '0;
    a1 = '0;
    br = '0;
    casez (insn[31:15])
        17'b0001010_??????????: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_LU12I};
        17'b0000001000_???????: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SLTI};
        17'b0000001001_???????: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SLTUI};
        17'b0000001010_???????: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_ADDI};
        17'b0000001101_???????: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_ANDI};
        17'b0000001110_???????: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_ORI};
        17'b0000001111_???????: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_XORI};
        17'b00000000010000001:  {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SLLI};
        17'b00000000010001001:  {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SRLI};
        17'b00000000010010001:  {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SRAI};
        17'b000000000001_00000: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_ADD};
        17'b000000000001_00010: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SUB};
        17'b000000000001_00100: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SLT};
        17'b000000000001_00101: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SLTU};
        17'b000000000001_01000: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_NOR};
        17'b000000000001_01001: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_AND};
        17'b000000000001_01010: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_OR};
        17'b000000000001_01011: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_XOR};
        17'b000000000001_01110: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SLL};
        17'b000000000001_01111: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SRL};
        17'b000000000001_10000: {q, a0} = {decode_pkg::IQ_ALU0, decode_pkg::ALU0_SRA};
        17'b000000000001110_00: {q, a1} = {decode_pkg::IQ_ALU1, decode_pkg::ALU1_MUL};
        17'b000000000001110_01: {q, a1} = {decode_pkg::IQ_ALU1, decode_pkg::ALU1_MULH};
        17'b000000000001110_10: {q, a1} = {decode_pkg::IQ_ALU1, decode_pkg::ALU1_MULHU};
        17'b000000000010000_00: {q, a1} = {decode_pkg::IQ_ALU1, decode_pkg::ALU1_DIV};
        17'b000000000010000_01: {q, a1} = {decode_pkg::IQ_ALU1, decode_pkg::ALU1_MOD};
        17'b000000000010000_10: {q, a1} = {decode_pkg::IQ_ALU1, decode_pkg::ALU1_DIVU};
        17'b000000000010000_11: {q, a1} = {decode_pkg::IQ_ALU1, decode_pkg::ALU1_MODU};
        17'b0001110_??????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_PCADDU12I};
        17'b010011_???????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_JIRL};
        17'b010100_???????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_B};
        17'b010101_???????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_BL};
        17'b010110_???????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_BEQ};
        17'b010111_???????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_BNE};
        17'b011000_???????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_BLT};
        17'b011001_???????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_BGE};
        17'b011010_???????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_BLTU};
        17'b011011_???????????: {q, br} = {decode_pkg::IQ_BRU, decode_pkg::BRU_BGEU};
        default: q = decode_pkg::IQ_NONE;
    endcase
    if (!valid) begin
        q = decode_pkg::IQ_NONE;
    end
    ill = valid && (q == decode_pkg::IQ_NONE);
    if (q == decode_pkg::IQ_NONE) begin
        return u;
    end
    cond_br = (q == decode_pkg::IQ_BRU) && (br >= decode_pkg::BRU_BEQ);
    u.valid     = 1'b1;
    u.queue     = decode_pkg::iq_e'(q);
    u.regs.src1 = insn[9:5];
    u.regs.src2 = cond_br ? insn[4:0] : insn[14:10];   // rd is the second compare operand
    u.regs.dst  = (q == decode_pkg::IQ_BRU && br == decode_pkg::BRU_BL) ?
                  `REG_IDX_W'(`LINK_REG) : insn[4:0];
    case (q)
        decode_pkg::IQ_ALU0: begin
            u.ops.alu0_op  = decode_pkg::alu0_op_e'(a0);
            u.ops.alu_imm  = (a0 == decode_pkg::ALU0_LU12I) ? insn[24:5] : {8'd0, insn[21:10]};
            u.regs.dst_en  = 1'b1;
            u.regs.src1_en = (a0 != decode_pkg::ALU0_LU12I);
            u.regs.src2_en = (a0 >= decode_pkg::ALU0_ADD) && (a0 <= decode_pkg::ALU0_SRA);
        end
        decode_pkg::IQ_ALU1: begin
            u.ops.alu1_op  = decode_pkg::alu1_op_e'(a1);
            u.regs.dst_en  = 1'b1;
            u.regs.src1_en = 1'b1;
            u.regs.src2_en = 1'b1;
        end
        default: begin
            u.ops.bru_op = decode_pkg::bru_op_e'(br);
            if (br == decode_pkg::BRU_PCADDU12I) begin
                u.ops.bru_imm = {6'd0, insn[24:5]};
            end else if (br == decode_pkg::BRU_B || br == decode_pkg::BRU_BL) begin
                u.ops.bru_imm = {insn[9:0], insn[25:10]};      // offs[25:16] sits low
            end else begin
                u.ops.bru_imm = {10'd0, insn[25:10]};
            end
            u.regs.dst_en  = (br == decode_pkg::BRU_JIRL) || (br == decode_pkg::BRU_BL) ||
                             (br == decode_pkg::BRU_PCADDU12I);
            u.regs.src1_en = (br == decode_pkg::BRU_JIRL) || cond_br;
            u.regs.src2_en = cond_br;
        end
    endcase
    return u;
endfunction

`endif

/* sim/tb_decode_top.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module tb_decode_top;

    localparam int NUM_TESTS    = 2000;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS      = 38;

    // Opcode bits of every kept instruction, other fields left zero
    localparam logic [31:0] OP_MATCH [NUM_OPS] = '{
        32'h1400_0000, 32'h0200_0000, 32'h0240_0000, 32'h0280_0000,
        32'h0340_0000, 32'h0380_0000, 32'h03C0_0000, 32'h0040_8000,
        32'h0044_8000, 32'h0048_8000, 32'h0010_0000, 32'h0011_0000,
        32'h0012_0000, 32'h0012_8000, 32'h0014_0000, 32'h0014_8000,
        32'h0015_0000, 32'h0015_8000, 32'h0017_0000, 32'h0017_8000,
        32'h0018_0000, 32'h001C_0000, 32'h001C_8000, 32'h001D_0000,
        32'h0020_0000, 32'h0020_8000, 32'h0021_0000, 32'h0021_8000,
        32'h1C00_0000, 32'h4C00_0000, 32'h5000_0000, 32'h5400_0000,
        32'h5800_0000, 32'h5C00_0000, 32'h6000_0000, 32'h6400_0000,
        32'h6800_0000, 32'h6C00_0000
    };

    logic                   clk;
    logic                   rst_n;
    decode_pkg::fetch_pkt_t fetch;
    logic                   hold;
    logic                   flush;
    decode_pkg::uop_t       uop;
    logic [`PC_W-1:0]       pc_out;
    logic                   illegal;

    decode_pkg::uop_t       exp_uop;
    logic [`PC_W-1:0]       exp_pc;
    logic                   exp_ill;
    int                     errors = 0;

    `include "decode_ref.svh"

    decode_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .fetch   (fetch),
        .hold    (hold),
        .flush   (flush),
        .uop     (uop),
        .pc_out  (pc_out),
        .illegal (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] opcode_mask(input logic [31:0] m);
        if (m[30]) begin
            return 32'hFC00_0000;       // Branches, 6-bit opcode
        end else if (m[28]) begin
            return 32'hFE00_0000;       // LU12I and PCADDU12I
        end else if (m[25]) begin
            return 32'hFFC0_0000;
        end
        return 32'hFFFF_8000;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_stimulus();
        logic [31:0] m;
        int pick;
        pick = $urandom_range(0, NUM_OPS + 9);
        if (pick < NUM_OPS) begin
            m = OP_MATCH[pick];
            fetch.insn = ($urandom() & ~opcode_mask(m)) | m;
        end else begin
            fetch.insn = $urandom();    // Mostly illegal words
        end
        fetch.valid = ($urandom_range(0, 7) != 0);
        fetch.pc    = $urandom() & 32'hFFFF_FFFC;
        hold        = ($urandom_range(0, 5) == 0);
        flush       = ($urandom_range(0, 9) == 0);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        fetch = '0;
        hold  = 1'b0;
        flush = 1'b0;
        void'($urandom(57));
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            drive_stimulus();
            @(negedge clk);
        end
        fetch = '0;
        hold  = 1'b0;
        flush = 1'b0;
        repeat (2) @(negedge clk);
        $display("Run complete, %0d tests, %0d errors", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // One-entry model of the stage register, checked once outputs settle
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_uop = '0;
            exp_pc  = '0;
            exp_ill = 1'b0;
        end else if (flush) begin
            exp_uop = '0;
            exp_ill = 1'b0;
        end else if (!hold) begin
            exp_uop = ref_decode(fetch.valid, fetch.insn, exp_ill);
            if (fetch.valid) begin
                exp_pc = fetch.pc;
            end
        end
        #5;
        compare("uop.valid", 32'(uop.valid), 32'(exp_uop.valid));
        compare("uop.queue", 32'(uop.queue), 32'(exp_uop.queue));
        compare("uop.alu0_op", 32'(uop.ops.alu0_op), 32'(exp_uop.ops.alu0_op));
        compare("uop.alu1_op", 32'(uop.ops.alu1_op), 32'(exp_uop.ops.alu1_op));
        compare("uop.bru_op", 32'(uop.ops.bru_op), 32'(exp_uop.ops.bru_op));
        compare("uop.alu_imm", 32'(uop.ops.alu_imm), 32'(exp_uop.ops.alu_imm));
        compare("uop.bru_imm", 32'(uop.ops.bru_imm), 32'(exp_uop.ops.bru_imm));
        compare("uop.dst_en", 32'(uop.regs.dst_en), 32'(exp_uop.regs.dst_en));
        compare("uop.dst", 32'(uop.regs.dst), 32'(exp_uop.regs.dst));
        compare("uop.src1_en", 32'(uop.regs.src1_en), 32'(exp_uop.regs.src1_en));
        compare("uop.src1", 32'(uop.regs.src1), 32'(exp_uop.regs.src1));
        compare("uop.src2_en", 32'(uop.regs.src2_en), 32'(exp_uop.regs.src2_en));
        compare("uop.src2", 32'(uop.regs.src2), 32'(exp_uop.regs.src2));
        compare("pc_out", pc_out, exp_pc);
        compare("illegal", 32'(illegal), 32'(exp_ill));
    end

    initial begin
        #(NUM_TESTS * 2 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        $display("Timeout, the stimulus did not finish within the expected run time");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
+incdir+sim
design/decode_pkg.sv
design/iq_classifier.sv
design/op_decoder.sv
design/operand_decoder.sv
design/decode_stage_reg.sv
design/decode_top.sv
sim/tb_decode_top.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_decode_top -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_decode_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
